//--- backendPkg.sv
package backendPkg;

    localparam int NumArchRegs = 32;
    localparam int NumTags = 48;
    localparam int RobDepth = 16;
    localparam int DataW = 32;

    typedef logic [$clog2(NumArchRegs)-1:0] archReg_t;
    typedef logic [$clog2(NumTags)-1:0] tag_t;

    // wraps modulo RobDepth, also used as the rob index
    typedef logic [$clog2(RobDepth)-1:0] sqN_t;

    typedef logic [DataW-1:0] data_t;

    typedef enum logic [1:0] {
        ENTRY_FREE,
        ENTRY_WAIT,
        ENTRY_DONE
    } entryState_e;

    typedef enum logic {
        SLOT_EMPTY,
        SLOT_FULL
    } slotState_e;

endpackage

//--- dispatchControl.sv
module dispatchControl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispValid,
    input  backendPkg::archReg_t dispDst,
    input  logic                 issueReady,
    input  logic                 robFull,
    input  logic                 freeEmpty,
    input  backendPkg::tag_t     srcTag,
    input  backendPkg::tag_t     freeTag,
    input  backendPkg::sqN_t     allocSqN,
    output logic                 dispReady,
    output logic                 alloc,
    output logic                 popTag,
    output backendPkg::tag_t     allocTag,
    output logic                 issueValid,
    output backendPkg::sqN_t     issueSqN,
    output backendPkg::tag_t     issueTagSrc,
    output backendPkg::tag_t     issueTagDst
);

    backendPkg::slotState_e slotState;
    logic dstZero;
    logic slotFree;

    // r0 never gets a physical register
    assign dstZero = dispDst == '0;

    // slot is empty now or drains on this edge
    assign slotFree = (slotState == backendPkg::SLOT_EMPTY) || issueReady;

    assign dispReady = !robFull && !freeEmpty && slotFree;
    assign alloc = dispValid && dispReady;
    assign popTag = alloc && !dstZero;
    assign allocTag = dstZero ? '0 : freeTag;

    assign issueValid = slotState == backendPkg::SLOT_FULL;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotState <= backendPkg::SLOT_EMPTY;
        end else if (alloc) begin
            slotState <= backendPkg::SLOT_FULL;
        end else if (issueReady) begin
            slotState <= backendPkg::SLOT_EMPTY;
        end
    end

    // fields only move on an accepted dispatch, so they hold while stalled
    always_ff @(posedge clk) begin
        if (alloc) begin
            issueSqN <= allocSqN;
            issueTagSrc <= srcTag;
            issueTagDst <= allocTag;
        end
    end

endmodule

//--- renameTable.sv
module renameTable (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,
    input  backendPkg::archReg_t dispSrc,
    input  backendPkg::archReg_t dispDst,
    input  backendPkg::tag_t     allocTag,
    input  logic                 commit,
    input  backendPkg::archReg_t comDst,
    input  backendPkg::tag_t     comTag,
    input  backendPkg::archReg_t archAddr,
    output backendPkg::tag_t     srcTag,
    output backendPkg::tag_t     oldTag,
    output backendPkg::tag_t     archTag
);

    backendPkg::tag_t specMap[backendPkg::NumArchRegs];
    backendPkg::tag_t commitMap[backendPkg::NumArchRegs];

    // lookups see the map before this cycle's alloc
    assign srcTag = specMap[dispSrc];
    assign oldTag = specMap[dispDst];

    assign archTag = commitMap[archAddr];

    // speculative map follows dispatch
    // a dst of r0 rewrites tag 0 into entry 0, which leaves it unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < backendPkg::NumArchRegs; i++) begin
                specMap[i] <= backendPkg::tag_t'(i);
            end
        end else if (alloc) begin
            specMap[dispDst] <= allocTag;
        end
    end

    // committed map follows the rob head
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < backendPkg::NumArchRegs; i++) begin
                commitMap[i] <= backendPkg::tag_t'(i);
            end
        end else if (commit) begin
            commitMap[comDst] <= comTag;
        end
    end

endmodule

//--- freeList.sv
module freeList (
    input  logic             clk,
    input  logic             rst,
    input  logic             popTag,
    output backendPkg::tag_t freeTag,
    output logic             freeEmpty,
    input  logic             pushTag,
    input  backendPkg::tag_t comOldTag
);

    localparam int Depth = backendPkg::NumTags - backendPkg::NumArchRegs;
    localparam int PtrW = $clog2(Depth);
    localparam int CntW = $clog2(Depth + 1);

    backendPkg::tag_t tagMem[Depth];
    logic [PtrW-1:0] head;
    logic [PtrW-1:0] tail;
    logic [CntW-1:0] count;

    assign freeTag = tagMem[head];
    assign freeEmpty = count == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            // starts full with the tags above the arch identity map
            for (int i = 0; i < Depth; i++) begin
                tagMem[i] <= backendPkg::tag_t'(backendPkg::NumArchRegs + i);
            end
            head <= '0;
            tail <= '0;
            count <= CntW'(Depth);
        end else begin
            if (pushTag) begin
                tagMem[tail] <= comOldTag;
                tail <= tail + 1'b1;
            end
            if (popTag) begin
                head <= head + 1'b1;
            end
            case ({pushTag, popTag})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- reorderBuffer.sv
module reorderBuffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,
    input  backendPkg::archReg_t dispDst,
    input  backendPkg::tag_t     allocTag,
    input  backendPkg::tag_t     oldTag,
    input  logic                 wbValid,
    input  backendPkg::sqN_t     wbSqN,
    input  backendPkg::data_t    wbResult,
    output logic                 robFull,
    output backendPkg::sqN_t     allocSqN,
    output logic                 rfWe,
    output backendPkg::tag_t     rfWaddr,
    output backendPkg::data_t    rfWdata,
    output logic                 commit,
    output backendPkg::archReg_t comDst,
    output backendPkg::tag_t     comTag,
    output backendPkg::tag_t     comOldTag,
    output logic                 pushTag,
    output logic                 comValid
);

    localparam int CntW = $clog2(backendPkg::RobDepth + 1);

    backendPkg::entryState_e entryState[backendPkg::RobDepth];
    backendPkg::archReg_t dstMem[backendPkg::RobDepth];
    backendPkg::tag_t tagMem[backendPkg::RobDepth];
    backendPkg::tag_t oldTagMem[backendPkg::RobDepth];

    backendPkg::sqN_t head;
    backendPkg::sqN_t tail;
    logic [CntW-1:0] count;

    assign robFull = count == CntW'(backendPkg::RobDepth);
    assign allocSqN = tail;

    // result goes straight into the prf, tag 0 has no storage
    assign rfWaddr = tagMem[wbSqN];
    assign rfWdata = wbResult;
    assign rfWe = wbValid && (rfWaddr != '0);

    // in-order retire, one per cycle
    assign commit = entryState[head] == backendPkg::ENTRY_DONE;
    assign comValid = commit;
    assign comDst = dstMem[head];
    assign comTag = tagMem[head];
    assign comOldTag = oldTagMem[head];
    assign pushTag = commit && (comOldTag != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < backendPkg::RobDepth; i++) begin
                entryState[i] <= backendPkg::ENTRY_FREE;
            end
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                entryState[tail] <= backendPkg::ENTRY_WAIT;
                tail <= tail + 1'b1;
            end
            // wb only ever targets a waiting entry, never head or tail here
            if (wbValid) begin
                entryState[wbSqN] <= backendPkg::ENTRY_DONE;
            end
            if (commit) begin
                entryState[head] <= backendPkg::ENTRY_FREE;
                head <= head + 1'b1;
            end
            case ({alloc, commit})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            dstMem[tail] <= dispDst;
            tagMem[tail] <= allocTag;
            oldTagMem[tail] <= oldTag;
        end
    end

endmodule

//--- physRegFile.sv
module physRegFile (
    input  logic              clk,
    input  logic              rst,
    input  logic              rfWe,
    input  backendPkg::tag_t  rfWaddr,
    input  backendPkg::data_t rfWdata,
    input  backendPkg::tag_t  comTag,
    output backendPkg::data_t comResult,
    input  backendPkg::tag_t  archTag,
    output backendPkg::data_t archData
);

    backendPkg::data_t regs[backendPkg::NumTags];

    // tag 0 backs r0 and always reads zero
    assign comResult = (comTag == '0) ? '0 : regs[comTag];
    assign archData = (archTag == '0) ? '0 : regs[archTag];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < backendPkg::NumTags; i++) begin
                regs[i] <= '0;
            end
        end else if (rfWe) begin
            regs[rfWaddr] <= rfWdata;
        end
    end

endmodule

//--- renameBackend.sv
module renameBackend (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispValid,
    output logic                 dispReady,
    input  backendPkg::archReg_t dispSrc,
    input  backendPkg::archReg_t dispDst,
    output logic                 issueValid,
    input  logic                 issueReady,
    output backendPkg::sqN_t     issueSqN,
    output backendPkg::tag_t     issueTagSrc,
    output backendPkg::tag_t     issueTagDst,
    input  logic                 wbValid,
    input  backendPkg::sqN_t     wbSqN,
    input  backendPkg::data_t    wbResult,
    output logic                 comValid,
    output backendPkg::archReg_t comDst,
    output backendPkg::data_t    comResult,
    input  backendPkg::archReg_t archAddr,
    output backendPkg::data_t    archData
);

    logic alloc;
    logic popTag;
    logic pushTag;
    logic freeEmpty;
    logic robFull;
    logic commit;
    logic rfWe;
    backendPkg::tag_t allocTag;
    backendPkg::tag_t freeTag;
    backendPkg::tag_t srcTag;
    backendPkg::tag_t oldTag;
    backendPkg::tag_t archTag;
    backendPkg::tag_t comTag;
    backendPkg::tag_t comOldTag;
    backendPkg::tag_t rfWaddr;
    backendPkg::sqN_t allocSqN;
    backendPkg::data_t rfWdata;

    dispatchControl ctrl_i (
        .clk(clk),
        .rst(rst),
        .dispValid(dispValid),
        .dispDst(dispDst),
        .issueReady(issueReady),
        .robFull(robFull),
        .freeEmpty(freeEmpty),
        .srcTag(srcTag),
        .freeTag(freeTag),
        .allocSqN(allocSqN),
        .dispReady(dispReady),
        .alloc(alloc),
        .popTag(popTag),
        .allocTag(allocTag),
        .issueValid(issueValid),
        .issueSqN(issueSqN),
        .issueTagSrc(issueTagSrc),
        .issueTagDst(issueTagDst)
    );

    renameTable rt_i (
        .clk(clk),
        .rst(rst),
        .alloc(alloc),
        .dispSrc(dispSrc),
        .dispDst(dispDst),
        .allocTag(allocTag),
        .commit(commit),
        .comDst(comDst),
        .comTag(comTag),
        .archAddr(archAddr),
        .srcTag(srcTag),
        .oldTag(oldTag),
        .archTag(archTag)
    );

    freeList fl_i (
        .clk(clk),
        .rst(rst),
        .popTag(popTag),
        .freeTag(freeTag),
        .freeEmpty(freeEmpty),
        .pushTag(pushTag),
        .comOldTag(comOldTag)
    );

    reorderBuffer rob_i (
        .clk(clk),
        .rst(rst),
        .alloc(alloc),
        .dispDst(dispDst),
        .allocTag(allocTag),
        .oldTag(oldTag),
        .wbValid(wbValid),
        .wbSqN(wbSqN),
        .wbResult(wbResult),
        .robFull(robFull),
        .allocSqN(allocSqN),
        .rfWe(rfWe),
        .rfWaddr(rfWaddr),
        .rfWdata(rfWdata),
        .commit(commit),
        .comDst(comDst),
        .comTag(comTag),
        .comOldTag(comOldTag),
        .pushTag(pushTag),
        .comValid(comValid)
    );

    physRegFile prf_i (
        .clk(clk),
        .rst(rst),
        .rfWe(rfWe),
        .rfWaddr(rfWaddr),
        .rfWdata(rfWdata),
        .comTag(comTag),
        .comResult(comResult),
        .archTag(archTag),
        .archData(archData)
    );

endmodule

//--- renameBackend_chk.sv
module renameBackend_chk (
    input logic                    clk,
    input logic                    rst,
    input backendPkg::entryState_e tailState,
    input logic                    dispReady,
    input logic                    issueValid,
    input logic                    issueReady,
    input backendPkg::sqN_t        issueSqN,
    input backendPkg::tag_t        issueTagSrc,
    input backendPkg::tag_t        issueTagDst,
    input logic                    wbValid,
    input backendPkg::entryState_e wbState
);

    timeunit 1ns;
    timeprecision 1ps;

    // full means the entry at the tail is still in flight
    noDispWhenFull: assert property (@(posedge clk) disable iff (rst)
        tailState != backendPkg::ENTRY_FREE |-> !dispReady)
        else $error("dispatch ready while the tail entry is occupied");

    // slot contents hold while the consumer stalls
    issueStable: assert property (@(posedge clk) disable iff (rst)
        issueValid && !issueReady |=> issueValid && $stable(issueSqN)
            && $stable(issueTagSrc) && $stable(issueTagDst))
        else $error("issue outputs changed under back-pressure");

    wbOnWaiting: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> wbState == backendPkg::ENTRY_WAIT)
        else $error("writeback to an entry that is not waiting");

endmodule

bind renameBackend renameBackend_chk chk_i (
    .clk(clk),
    .rst(rst),
    .tailState(rob_i.entryState[rob_i.allocSqN]),
    .dispReady(dispReady),
    .issueValid(issueValid),
    .issueReady(issueReady),
    .issueSqN(issueSqN),
    .issueTagSrc(issueTagSrc),
    .issueTagDst(issueTagDst),
    .wbValid(wbValid),
    .wbState(rob_i.entryState[wbSqN])
);

//--- renameBackend_tb.sv
module renameBackend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MaxCycles = 3000;

    logic clk;
    logic rst;
    logic dispValid;
    logic dispReady;
    backendPkg::archReg_t dispSrc;
    backendPkg::archReg_t dispDst;
    logic issueValid;
    logic issueReady;
    backendPkg::sqN_t issueSqN;
    backendPkg::tag_t issueTagSrc;
    backendPkg::tag_t issueTagDst;
    logic wbValid;
    backendPkg::sqN_t wbSqN;
    backendPkg::data_t wbResult;
    logic comValid;
    backendPkg::archReg_t comDst;
    backendPkg::data_t comResult;
    backendPkg::archReg_t archAddr;
    backendPkg::data_t archData;

    // reference model
    backendPkg::data_t refArch[backendPkg::NumArchRegs];
    backendPkg::archReg_t expDst[backendPkg::RobDepth];
    backendPkg::data_t expRes[backendPkg::RobDepth];
    logic wbDone[backendPkg::RobDepth];
    backendPkg::sqN_t nextSqN;
    backendPkg::sqN_t comPtr;
    int commitCount;
    int cycles;
    int dispCount;

    renameBackend dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("Timeout after %0d cycles waiting on the DUT", cycles);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "check failed");
    endtask

    task automatic compareBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            failNow($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic compareTag(input backendPkg::tag_t got, input backendPkg::tag_t exp,
                              input string what);
        if (got !== exp) begin
            failNow($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic compareSqN(input backendPkg::sqN_t got, input backendPkg::sqN_t exp,
                              input string what);
        if (got !== exp) begin
            failNow($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic compareArch(input backendPkg::archReg_t got, input backendPkg::archReg_t exp,
                               input string what);
        if (got !== exp) begin
            failNow($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic compareData(input backendPkg::data_t got, input backendPkg::data_t exp,
                               input string what);
        if (got !== exp) begin
            failNow($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    // commit is visible at negedge and takes effect on the next rising edge
    always @(negedge clk) begin
        if (!rst && comValid) begin
            if (!wbDone[comPtr]) begin
                failNow("commit appeared before the oldest micro-op was written back");
            end
            compareArch(comDst, expDst[comPtr], "comDst");
            compareData(comResult, (expDst[comPtr] == '0) ? '0 : expRes[comPtr], "comResult");
            if (expDst[comPtr] != '0) begin
                refArch[expDst[comPtr]] = expRes[comPtr];
            end
            wbDone[comPtr] = 1'b0;
            comPtr = comPtr + 1'b1;
            commitCount++;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic dispatchOp(input backendPkg::archReg_t src, input backendPkg::archReg_t dst,
                              output backendPkg::tag_t tagSrc, output backendPkg::tag_t tagDst);
        dispValid = 1'b1;
        dispSrc = src;
        dispDst = dst;
        #1;
        while (!dispReady) begin
            @(posedge clk);
            #3;
        end
        expDst[nextSqN] = dst;
        wbDone[nextSqN] = 1'b0;
        nextCycle();
        dispValid = 1'b0;
        compareBit(issueValid, 1'b1, "issueValid after dispatch");
        compareSqN(issueSqN, nextSqN, "issueSqN");
        tagSrc = issueTagSrc;
        tagDst = issueTagDst;
        nextSqN = nextSqN + 1'b1;
        dispCount++;
    endtask

    task automatic writeBack(input backendPkg::sqN_t sqN, input backendPkg::data_t value);
        wbValid = 1'b1;
        wbSqN = sqN;
        wbResult = value;
        expRes[sqN] = value;
        nextCycle();
        wbValid = 1'b0;
        wbDone[sqN] = 1'b1;
    endtask

    task automatic waitCommits(input int total);
        while (commitCount < total) begin
            nextCycle();
        end
    endtask

    task automatic checkArchAll();
        for (int r = 0; r < backendPkg::NumArchRegs; r++) begin
            archAddr = backendPkg::archReg_t'(r);
            #1;
            compareData(archData, refArch[r], $sformatf("archData r%0d", r));
            nextCycle();
        end
    endtask

    task automatic testReset();
        compareBit(dispReady, 1'b1, "dispReady after reset");
        compareBit(issueValid, 1'b0, "issueValid after reset");
        compareBit(comValid, 1'b0, "comValid after reset");
        checkArchAll();
    endtask

    task automatic testSingle();
        backendPkg::tag_t ts;
        backendPkg::tag_t td;
        dispatchOp(5'd3, 5'd7, ts, td);
        // first free tag after reset is NumArchRegs, source still on identity map
        compareTag(ts, 6'd3, "issueTagSrc single");
        compareTag(td, 6'd32, "issueTagDst single");
        writeBack(nextSqN - 1'b1, 32'hCAFE_0007);
        waitCommits(dispCount);
        checkArchAll();
    endtask

    task automatic testOutOfOrder();
        backendPkg::tag_t ts;
        backendPkg::tag_t td;
        backendPkg::sqN_t first;
        first = nextSqN;
        for (int i = 0; i < 4; i++) begin
            dispatchOp(5'd1, backendPkg::archReg_t'(10 + i), ts, td);
        end
        for (int i = 3; i >= 0; i--) begin
            writeBack(first + backendPkg::sqN_t'(i), 32'h1000 + i);
            if (i > 0) begin
                compareBit(comValid, 1'b0, "comValid before oldest done");
            end
        end
        waitCommits(dispCount);
        checkArchAll();
    endtask

    task automatic testRenaming();
        backendPkg::tag_t ts;
        backendPkg::tag_t td;
        backendPkg::tag_t prevDst;
        dispatchOp(5'd2, 5'd9, ts, prevDst);
        dispatchOp(5'd9, 5'd9, ts, td);
        compareTag(ts, prevDst, "issueTagSrc follows older dst");
        dispatchOp(5'd4, 5'd0, ts, td);
        compareTag(td, 6'd0, "issueTagDst for r0");
        writeBack(nextSqN - 2'd2, 32'h2222);
        writeBack(nextSqN - 2'd3, 32'h1111);
        writeBack(nextSqN - 2'd1, 32'h9999);
        waitCommits(dispCount);
        checkArchAll();
    endtask

    task automatic testBackPressure();
        backendPkg::tag_t ts;
        backendPkg::tag_t td;
        backendPkg::sqN_t first;
        int accepted;
        first = nextSqN;
        issueReady = 1'b0;
        dispatchOp(5'd5, 5'd6, ts, td);
        // a pending dispatch waits behind the held slot
        dispValid = 1'b1;
        dispSrc = 5'd1;
        dispDst = 5'd20;
        for (int i = 0; i < 4; i++) begin
            #1;
            compareBit(dispReady, 1'b0, "dispReady with slot held");
            nextCycle();
            compareBit(issueValid, 1'b1, "issueValid held");
            compareSqN(issueSqN, first, "issueSqN held");
            compareTag(issueTagSrc, ts, "issueTagSrc held");
            compareTag(issueTagDst, td, "issueTagDst held");
        end
        issueReady = 1'b1;
        accepted = 1;
        for (int i = 0; i < 24; i++) begin
            #1;
            if (dispReady) begin
                expDst[nextSqN] = dispDst;
                wbDone[nextSqN] = 1'b0;
                nextSqN = nextSqN + 1'b1;
                dispCount++;
                accepted++;
            end
            nextCycle();
        end
        dispValid = 1'b0;
        if (accepted != backendPkg::RobDepth) begin
            failNow($sformatf("reorder buffer accepted %0d micro-ops instead of 16", accepted));
        end
        compareBit(dispReady, 1'b0, "dispReady when full");
        for (int i = 0; i < backendPkg::RobDepth; i++) begin
            writeBack(first + backendPkg::sqN_t'(i), 32'h5000 + i);
        end
        waitCommits(dispCount);
        compareBit(dispReady, 1'b1, "dispReady after drain");
        checkArchAll();
    endtask

    task automatic testRandom();
        backendPkg::tag_t ts;
        backendPkg::tag_t td;
        backendPkg::sqN_t pending[$];
        int idx;
        for (int n = 0; n < 60; n++) begin
            dispatchOp(backendPkg::archReg_t'($urandom), backendPkg::archReg_t'($urandom), ts, td);
            pending.push_back(nextSqN - 1'b1);
            // keep a small window of outstanding writebacks
            if (pending.size() >= 4 || ($urandom % 3) == 0) begin
                // oldest goes first once it falls too far behind
                if (backendPkg::sqN_t'(nextSqN - pending[0]) >= 8) begin
                    idx = 0;
                end else begin
                    idx = $urandom % pending.size();
                end
                writeBack(pending[idx], $urandom);
                pending.delete(idx);
            end
        end
        while (pending.size() > 0) begin
            idx = $urandom % pending.size();
            writeBack(pending[idx], $urandom);
            pending.delete(idx);
        end
        waitCommits(dispCount);
        checkArchAll();
    endtask

    initial begin
        void'($urandom(60414));
        cycles = 0;
        rst = 1'b1;
        dispValid = 1'b0;
        dispSrc = '0;
        dispDst = '0;
        issueReady = 1'b1;
        wbValid = 1'b0;
        wbSqN = '0;
        wbResult = '0;
        archAddr = '0;
        nextSqN = '0;
        comPtr = '0;
        commitCount = 0;
        dispCount = 0;
        for (int i = 0; i < backendPkg::NumArchRegs; i++) begin
            refArch[i] = '0;
        end
        for (int i = 0; i < backendPkg::RobDepth; i++) begin
            wbDone[i] = 1'b0;
            expRes[i] = '0;
            expDst[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        testReset();
        testSingle();
        testOutOfOrder();
        testRenaming();
        testBackPressure();
        testRandom();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- renameBackend.f
backendPkg.sv
dispatchControl.sv
renameTable.sv
freeList.sv
reorderBuffer.sv
physRegFile.sv
renameBackend.sv
renameBackend_chk.sv
renameBackend_tb.sv

//--- run.sh
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert --top-module renameBackend_tb -f renameBackend.f -o simv \
    && ./obj_dir/simv | tee sim.log \
    || { echo "build or simulation error"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
